/* spiCsrPkg.sv */
`default_nettype none

package spiCsrPkg;

	// --------------------
	// widths
	// --------------------

	// spi word and register data width
	localparam int cUsiBusWidth = 32;
	// address word plus data word
	localparam int cFrameBits = 64;
	// frame bit counter width
	localparam int cBitCntW = $clog2(cFrameBits);
	// index field in address bits 3..0
	localparam int cRegIdxBits = 4;

	// --------------------
	// register map
	// --------------------

	// implemented registers, rest of index space reads zero
	localparam int cRegCount = 8;
	// read-only id at index 0, ascii "SPIC"
	localparam logic [cUsiBusWidth-1:0] cIdValue = 32'h5350_4943;

	// --------------------
	// encodings
	// --------------------

	// opcode in address bits 31..30, 2'b01 decodes as idle
	typedef enum logic [1:0] {
		opIdle  = 2'b00,
		opWrite = 2'b10,
		opRead  = 2'b11
	} usiOpE;

	// framer phases
	typedef enum logic [1:0] {
		stIdle,
		stAdrs,
		stData
	} frameStateE;

endpackage

`default_nettype wire

/* spiWordIf.sv */
`default_nettype none

interface spiWordIf import spiCsrPkg::*; ();

	// last complete word shifted in from mosi
	logic [cUsiBusWidth-1:0] rd;
	// address word done, one cycle
	logic adrsEd;
	// data word done, one cycle
	logic dataEd;
	// csr read data headed back to the framer
	logic [cUsiBusWidth-1:0] miso;

	// framer side
	modport frame (
		output rd, adrsEd, dataEd,
		input  miso
	);

	// bridge side
	modport bridge (
		input  rd, adrsEd, dataEd,
		output miso
	);

endinterface

`default_nettype wire

/* spiSlaveFrame.sv */
`default_nettype none

module spiSlaveFrame import spiCsrPkg::*; (
	input  wire  iSCLK,
	input  wire  arstN,
	input  wire  spiSck,
	input  wire  spiCsN,
	input  wire  spiMosi,
	output logic spiMiso,
	spiWordIf.frame wordBus
);

	// --------------------
	// pin sync
	// --------------------

	// sck gets a third stage for edge detect
	logic [2:0] sckSr;
	logic [1:0] csSr;
	logic [1:0] mosiSr;
	logic sckRise;
	logic sckFall;
	logic csSync;

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			sckSr  <= '0;
			// chip select idles high
			csSr   <= 2'b11;
			mosiSr <= '0;
		end
		else
		begin
			sckSr  <= {sckSr[1:0], spiSck};
			csSr   <= {csSr[0], spiCsN};
			mosiSr <= {mosiSr[0], spiMosi};
		end
	end

	// edges on the second stage, lined up with mosiSr[1]
	assign sckRise = sckSr[1] & ~sckSr[2];
	assign sckFall = ~sckSr[1] & sckSr[2];
	assign csSync  = csSr[1];

	// --------------------
	// receive fsm
	// --------------------

	frameStateE state;
	logic [cBitCntW-1:0] bitCnt;
	logic [cUsiBusWidth-1:0] shiftIn;
	logic [cUsiBusWidth-1:0] shiftNext;

	// word including the bit being sampled now
	assign shiftNext = {shiftIn[cUsiBusWidth-2:0], mosiSr[1]};

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			state          <= stIdle;
			bitCnt         <= '0;
			wordBus.adrsEd <= 1'b0;
			wordBus.dataEd <= 1'b0;
		end
		else
		begin
			// strobes only live one cycle
			wordBus.adrsEd <= 1'b0;
			wordBus.dataEd <= 1'b0;
			if (csSync)
			begin
				// deselect or abort, drop the partial frame
				state  <= stIdle;
				bitCnt <= '0;
			end
			else
			begin
				case (state)
					stIdle:
					begin
						state  <= stAdrs;
						bitCnt <= '0;
					end
					stAdrs:
					begin
						if (sckRise)
						begin
							bitCnt <= bitCnt + 1'b1;
							// address bit 0 just sampled
							if (bitCnt == cBitCntW'(cUsiBusWidth - 1))
							begin
								wordBus.adrsEd <= 1'b1;
								state          <= stData;
							end
						end
					end
					stData:
					begin
						if (sckRise)
						begin
							bitCnt <= bitCnt + 1'b1;
							if (bitCnt == cBitCntW'(cFrameBits - 1))
							begin
								wordBus.dataEd <= 1'b1;
								state          <= stIdle;
							end
						end
					end
					default:
						state <= stIdle;
				endcase
			end
		end
	end

	// payload path, no reset
	always_ff @(posedge iSCLK)
	begin
		if (sckRise)
			shiftIn <= shiftNext;
		// publish each finished word with its strobe
		if (sckRise && !csSync && state != stIdle && bitCnt[cBitCntW-2:0] == '1)
			wordBus.rd <= shiftNext;
	end

	// --------------------
	// transmit
	// --------------------

	logic loadMiso;
	logic [cUsiBusWidth-1:0] misoShift;

	// bridge read data is settled one cycle after adrsEd
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			loadMiso <= 1'b0;
		else
			loadMiso <= wordBus.adrsEd;
	end

	always_ff @(posedge iSCLK)
	begin
		if (loadMiso)
			misoShift <= wordBus.miso;
		else if (sckFall && state == stData)
			misoShift <= {misoShift[cUsiBusWidth-2:0], 1'b0};
	end

	// msb goes out on the first data phase falling edge
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			spiMiso <= 1'b0;
		else if (state != stData || csSync)
			spiMiso <= 1'b0;
		else if (sckFall)
			spiMiso <= misoShift[cUsiBusWidth-1];
	end

	// --------------------
	// checks
	// --------------------

	// address and data strobes are distinct phases
	assert property (@(posedge iSCLK) disable iff (!arstN)
		!(wordBus.adrsEd && wordBus.dataEd));

	// no strobe visible once chip select is high
	assert property (@(posedge iSCLK) disable iff (!arstN)
		(wordBus.adrsEd || wordBus.dataEd) |-> !csSync);

endmodule

`default_nettype wire

/* spiBusBridge.sv */
`default_nettype none

module spiBusBridge import spiCsrPkg::*; (
	input  wire                     iSCLK,
	input  wire                     arstN,
	input  wire  [cUsiBusWidth-1:0] usiRd,
	output logic [cUsiBusWidth-1:0] usiWd,
	output logic [cUsiBusWidth-1:0] usiAdrs,
	spiWordIf.bridge wordBus
);

	// address word of the frame in flight
	logic [cUsiBusWidth-1:0] adrsHold;
	usiOpE newOp;
	usiOpE holdOp;

	// opcode of the word arriving now and of the held one
	assign newOp  = usiOpE'(wordBus.rd[cUsiBusWidth-1:cUsiBusWidth-2]);
	assign holdOp = usiOpE'(adrsHold[cUsiBusWidth-1:cUsiBusWidth-2]);

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			adrsHold <= '0;
		else if (wordBus.adrsEd)
			adrsHold <= wordBus.rd;
	end

	// --------------------
	// bus access
	// --------------------

	// reads go out right after the address word,
	// writes wait for the data word
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			usiAdrs <= '0;
		else if (wordBus.adrsEd && newOp == opRead)
			usiAdrs <= wordBus.rd;
		else if (wordBus.dataEd && holdOp == opWrite)
			usiAdrs <= adrsHold;
		else
			usiAdrs <= '0;
	end

	// write data lines up with the write address
	always_ff @(posedge iSCLK)
	begin
		usiWd <= wordBus.rd;
	end

	// csr read data straight back to the framer
	assign wordBus.miso = usiRd;

	// one-cycle access only
	assert property (@(posedge iSCLK) disable iff (!arstN)
		(usiAdrs != '0) |=> (usiAdrs == '0));

endmodule

`default_nettype wire

/* csrRegBank.sv */
`default_nettype none

module csrRegBank import spiCsrPkg::*; (
	input  wire                     iSCLK,
	input  wire                     arstN,
	input  wire  [cUsiBusWidth-1:0] usiWd,
	input  wire  [cUsiBusWidth-1:0] usiAdrs,
	output logic [cUsiBusWidth-1:0] usiRd
);

	// --------------------
	// decode
	// --------------------

	usiOpE op;
	logic [cRegIdxBits-1:0] idx;
	logic wrEn;

	assign op   = usiOpE'(usiAdrs[cUsiBusWidth-1:cUsiBusWidth-2]);
	assign idx  = usiAdrs[cRegIdxBits-1:0];
	assign wrEn = (op == opWrite);

	// --------------------
	// storage
	// --------------------

	// index 0 is the id, not stored
	logic [cUsiBusWidth-1:0] regs [1:cRegCount-1];

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 1; i < cRegCount; i++)
				regs[i] <= '0;
		end
		else if (wrEn && idx != '0 && idx < cRegIdxBits'(cRegCount))
		begin
			regs[idx] <= usiWd;
		end
	end

	// read mux, straight from the index bits
	always_comb
	begin
		if (idx == '0)
			usiRd = cIdValue;
		else if (idx < cRegIdxBits'(cRegCount))
			usiRd = regs[idx];
		else
			// hole above the implemented range
			usiRd = '0;
	end

	// bridge must hand over a clean address every cycle
	assert property (@(posedge iSCLK) disable iff (!arstN)
		!$isunknown(usiAdrs));

endmodule

`default_nettype wire

/* spiCsrTop.sv */
`default_nettype none

module spiCsrTop import spiCsrPkg::*; (
	input  wire  iSCLK,
	input  wire  arstN,
	input  wire  spiSck,
	input  wire  spiCsN,
	input  wire  spiMosi,
	output logic spiMiso
);

	// framer to bridge words
	spiWordIf wordBus0 ();

	// bridge to register bank
	logic [cUsiBusWidth-1:0] usiAdrs;
	logic [cUsiBusWidth-1:0] usiWd;
	logic [cUsiBusWidth-1:0] usiRd;

	// --------------------
	// blocks
	// --------------------

	spiSlaveFrame frame0 (
		.iSCLK   (iSCLK),
		.arstN   (arstN),
		.spiSck  (spiSck),
		.spiCsN  (spiCsN),
		.spiMosi (spiMosi),
		.spiMiso (spiMiso),
		.wordBus (wordBus0.frame)
	);

	spiBusBridge bridge0 (
		.iSCLK   (iSCLK),
		.arstN   (arstN),
		.usiRd   (usiRd),
		.usiWd   (usiWd),
		.usiAdrs (usiAdrs),
		.wordBus (wordBus0.bridge)
	);

	csrRegBank regBank0 (
		.iSCLK   (iSCLK),
		.arstN   (arstN),
		.usiWd   (usiWd),
		.usiAdrs (usiAdrs),
		.usiRd   (usiRd)
	);

endmodule

`default_nettype wire

/* tbSpiCsr.sv */
`default_nettype none

module tbSpiCsr import spiCsrPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// --------------------
	// timing
	// --------------------

	// sck half period in iSCLK cycles
	localparam int cHalf = 8;
	localparam int cResetCycles = 10;
	// bits plus select lead, sck tail and gap
	localparam int cFrameCycles = 2 * cHalf * cFrameBits + 4 * cHalf;
	// 8 + 14 + 18 + 9 + 4 + 27 frames over the six tests
	localparam int cFrameCount = 80;
	// a quarter on top for slack
	localparam int cTimeoutCycles = cResetCycles + (cFrameCount * cFrameCycles * 5) / 4;
	// full index space, implemented registers and hole
	localparam int cIdxSpace = 1 << cRegIdxBits;

	logic iSCLK;
	logic arstN;
	logic spiSck;
	logic spiCsN;
	logic spiMosi;
	wire  spiMiso;

	// expected contents per the register map
	logic [cUsiBusWidth-1:0] model [0:cIdxSpace-1];
	logic [31:0] rngState;
	int cycleCnt = 0;
	int checkCount;
	int errCount;

	spiCsrTop dut0 (
		.iSCLK   (iSCLK),
		.arstN   (arstN),
		.spiSck  (spiSck),
		.spiCsN  (spiCsN),
		.spiMosi (spiMosi),
		.spiMiso (spiMiso)
	);

	// 40 ns clock
	always #20 iSCLK = ~iSCLK;

	// watchdog
	always @(posedge iSCLK)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cTimeoutCycles)
		begin
			$display("timeout: run still going after %0d clock cycles", cycleCnt);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// --------------------
	// helpers
	// --------------------

	// 13/17/5 xorshift
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRand();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
		checkCount++;
		assert (act === exp)
		else
		begin
			errCount++;
			$display("ERR %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	// mode 0 master, msb first, stops early when bitsToSend < cFrameBits
	task automatic spiFrame(
		input  logic [1:0]              op,
		input  int                      idx,
		input  logic [cUsiBusWidth-1:0] wrData,
		input  int                      bitsToSend,
		output logic [cUsiBusWidth-1:0] rdData
	);
		logic [cFrameBits-1:0] frameBits;
		int i;
		frameBits = {op, {(cUsiBusWidth-2-cRegIdxBits){1'b0}}, cRegIdxBits'(idx), wrData};
		rdData = '0;
		@(posedge iSCLK);
		spiCsN <= 1'b0;
		// give the framer time to see the select
		repeat (cHalf) @(posedge iSCLK);
		for (i = 0; i < bitsToSend; i++)
		begin
			// low half, mosi moves here
			@(posedge iSCLK);
			spiSck  <= 1'b0;
			spiMosi <= frameBits[cFrameBits-1-i];
			repeat (cHalf - 1) @(posedge iSCLK);
			// miso settled long ago, sample just before the rise
			@(negedge iSCLK);
			if (i >= cUsiBusWidth)
				rdData[cFrameBits-1-i] = spiMiso;
			@(posedge iSCLK);
			spiSck <= 1'b1;
			repeat (cHalf - 1) @(posedge iSCLK);
		end
		@(posedge iSCLK);
		spiSck  <= 1'b0;
		spiMosi <= 1'b0;
		repeat (cHalf) @(posedge iSCLK);
		spiCsN <= 1'b1;
		// inter-frame gap
		repeat (cHalf) @(posedge iSCLK);
	endtask

	task automatic writeReg(input int idx, input logic [31:0] data);
		logic [31:0] echo;
		spiFrame(opWrite, idx, data, cFrameBits, echo);
		// id and hole ignore writes
		if (idx != 0 && idx < cRegCount)
			model[idx] = data;
	endtask

	task automatic readReg(input int idx, output logic [31:0] data);
		spiFrame(opRead, idx, '0, cFrameBits, data);
	endtask

	// read back 1..cRegCount-1 against the model
	task automatic checkAllRegs(input string name);
		logic [31:0] got;
		int r;
		for (r = 1; r < cRegCount; r++)
		begin
			readReg(r, got);
			checkValue($sformatf("%s reg %0d", name, r), model[r], got);
		end
	endtask

	// --------------------
	// tests
	// --------------------

	task automatic resetValues();
		logic [31:0] got;
		int r;
		checkValue("resetValues miso", 32'h0, {31'h0, spiMiso});
		for (r = 0; r < cRegCount; r++)
		begin
			readReg(r, got);
			// id at 0, zeros elsewhere
			checkValue($sformatf("resetValues reg %0d", r), (r == 0) ? cIdValue : 32'h0, got);
		end
	endtask

	task automatic writeReadback();
		int r;
		for (r = 1; r < cRegCount; r++)
			writeReg(r, nextRand());
		checkAllRegs("writeReadback");
	endtask

	task automatic readOnlyAndHoles();
		logic [31:0] got;
		int r;
		writeReg(0, nextRand());
		readReg(0, got);
		checkValue("readOnlyAndHoles reg 0", cIdValue, got);
		for (r = cRegCount; r < cIdxSpace; r++)
			writeReg(r, nextRand());
		for (r = cRegCount; r < cIdxSpace; r++)
		begin
			readReg(r, got);
			checkValue($sformatf("readOnlyAndHoles reg %0d", r), 32'h0, got);
		end
	endtask

	task automatic idleFrameNoChange();
		logic [31:0] got;
		spiFrame(opIdle, 3, nextRand(), cFrameBits, got);
		// 01 decodes as idle too
		spiFrame(2'b01, 6, nextRand(), cFrameBits, got);
		checkAllRegs("idleFrameNoChange");
	endtask

	task automatic abortedFrame();
		logic [31:0] got;
		// select rises 8 bits into the data word
		spiFrame(opWrite, 4, ~model[4], 40, got);
		readReg(4, got);
		checkValue("abortedFrame after abort", model[4], got);
		writeReg(4, nextRand());
		readReg(4, got);
		checkValue("abortedFrame recovery", model[4], got);
	endtask

	task automatic backToBack();
		logic [31:0] got;
		int k;
		int a;
		int b;
		for (k = 0; k < 10; k++)
		begin
			// ping-pong between 2 and 5
			a = (k % 2 == 0) ? 2 : 5;
			b = (a == 2) ? 5 : 2;
			writeReg(a, nextRand());
			readReg(b, got);
			checkValue($sformatf("backToBack step %0d reg %0d", k, b), model[b], got);
		end
		checkAllRegs("backToBack");
	endtask

	// --------------------
	// main
	// --------------------

	initial
	begin
		int r;
		iSCLK = 1'b0;
		arstN = 1'b0;
		spiSck = 1'b0;
		spiCsN = 1'b1;
		spiMosi = 1'b0;
		rngState = 32'd61436;
		checkCount = 0;
		errCount = 0;
		for (r = 0; r < cIdxSpace; r++)
			model[r] = '0;
		model[0] = cIdValue;

		repeat (cResetCycles) @(posedge iSCLK);
		arstN <= 1'b1;
		repeat (cHalf) @(posedge iSCLK);

		resetValues();
		writeReadback();
		readOnlyAndHoles();
		idleFrameNoChange();
		abortedFrame();
		backToBack();

		$display("summary: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
spiCsrPkg.sv
spiWordIf.sv
spiSlaveFrame.sv
spiBusBridge.sv
csrRegBank.sv
spiCsrTop.sv
tbSpiCsr.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tbSpiCsr -f src.f -o simSpiCsr

status=0
./obj_dir/simSpiCsr > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
